// ==== pkt_tm.f ====
+incdir+design
design/tm_pkg.sv
design/pkt_xpt_buf.sv
design/pkt_rx_tm.sv
design/pkt_tx_tm.sv
design/pkt_tm.sv
tb/tb_pkt_tm.sv

// ==== Makefile ====
# Verilator flow for the packet switch.

VERILATOR ?= verilator
FLIST     ?= pkt_tm.f
TB_TOP    ?= tb_pkt_tm
RTL_TOP   ?= pkt_tm
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_pkt_tm.sv ====
// Table-driven testbench for the packet switch; compiled with the RTL through the file list.

`timescale 1ns/1ps
`include "tm_config.svh"

module tb_pkt_tm;

localparam int PW         = $bits(tm_pkg::port_id_t);
localparam int NUM_FRAMES = 33;
localparam int NUM_PHASES = 7;
localparam int TIMEOUT    = 3000;   // Cycles allowed for any one wait.
localparam int SETTLE     = 40;     // Quiet cycles that catch stray packets.

typedef struct packed {
    logic [3:0]         ph;
    tm_pkg::port_id_t   src;
    tm_pkg::port_id_t   dst;
    logic [`LEN_W-1:0]  len;
    logic               drop;
} frame_t;

logic                   clk_156m = 1'b0;
logic                   arst_n;
tm_pkg::port_vec_t      channel_up;
tm_pkg::ll_beat_t       rx_beat [`NUM_PORTS];
tm_pkg::port_vec_t      rx_src_rdy_n;
tm_pkg::ll_beat_t       tx_beat [`NUM_PORTS];
tm_pkg::port_vec_t      tx_src_rdy_n;
tm_pkg::port_vec_t      tx_dst_rdy_n;

frame_t                 tbl [NUM_FRAMES];
int                     exp_q [`NUM_PORTS][`NUM_PORTS][$];  // [input][output] entry indices.
logic                   busy [`NUM_PORTS] = '{default: 1'b0};
int                     cur_e [`NUM_PORTS];
int                     cur_k [`NUM_PORTS];
int                     senders_done;
int                     error_count = 0;
tm_pkg::port_vec_t      hold_mask = '0;
logic                   rand_bp = 1'b0;
logic [31:0]            rnd;

pkt_tm uut (
    .clk_156m       (clk_156m),
    .arst_n         (arst_n),
    .channel_up     (channel_up),
    .rx_beat        (rx_beat),
    .rx_src_rdy_n   (rx_src_rdy_n),
    .tx_beat        (tx_beat),
    .tx_src_rdy_n   (tx_src_rdy_n),
    .tx_dst_rdy_n   (tx_dst_rdy_n)
);

always #2 clk_156m = ~clk_156m;

// ------------------------------
// Helpers
// ------------------------------
function automatic frame_t make_frame(int ph, int src, int dst, int len, int drop);
    frame_t f;
    f.ph   = 4'(ph);
    f.src  = tm_pkg::port_id_t'(src);
    f.dst  = tm_pkg::port_id_t'(dst);
    f.len  = `LEN_W'(len);
    f.drop = (drop != 0);
    return f;
endfunction

function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Entry tag, source and destination packed into the first word.
function automatic tm_pkg::ll_beat_t exp_beat(int e, int k);
    tm_pkg::ll_beat_t b;
    logic             last;
    last    = (k == int'(tbl[e].len) - 1);
    b.data  = `DATA_W'(((e << (2 * PW)) | (int'(tbl[e].src) << PW) | int'(tbl[e].dst)) + k);
    b.rem   = last ? (e % 2 == 0) : 1'b1;
    b.sof_n = (k != 0);
    b.eof_n = !last;
    return b;
endfunction

function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
        for (int j = 0; j < `NUM_PORTS; j++)
            n += exp_q[i][j].size();
    for (int j = 0; j < `NUM_PORTS; j++)
        n += int'(busy[j]);
    return n;
endfunction

task automatic report_error(string msg);
    error_count++;
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
endtask

task automatic check_beat(string name, tm_pkg::ll_beat_t got, tm_pkg::ll_beat_t exp);
    if (got !== exp)
        report_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_port(string name, tm_pkg::port_id_t got, tm_pkg::port_id_t exp);
    if (got !== exp)
        report_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic tick();
    @(posedge clk_156m);
    #1;
endtask

task automatic send_frames(int src, int ph);
    for (int e = 0; e < NUM_FRAMES; e++)
    begin
        if (int'(tbl[e].ph) == ph && int'(tbl[e].src) == src)
        begin
            if (!tbl[e].drop)
                exp_q[src][tbl[e].dst].push_back(e);
            for (int k = 0; k < int'(tbl[e].len); k++)
            begin
                rx_beat[src]      = exp_beat(e, k);
                rx_src_rdy_n[src] = 1'b0;
                tick();
            end
            rx_src_rdy_n[src] = 1'b1;   // One idle cycle between frames.
            tick();
        end
    end
    senders_done++;
endtask

task automatic wait_phase_end(int ph);
    int n;
    n = 0;
    while (senders_done < `NUM_PORTS)
    begin
        tick();
        n++;
        if (n > TIMEOUT)
            report_error($sformatf("timeout: senders of phase %0d did not finish", ph));
    end
    hold_mask = '0;
    n = 0;
    while (outstanding() != 0)
    begin
        tick();
        n++;
        if (n > TIMEOUT)
            report_error($sformatf("timeout: packets of phase %0d did not arrive", ph));
    end
    repeat (SETTLE) tick();
endtask

// ------------------------------
// Output monitor
// ------------------------------
// Sampled at the falling edge, so a beat seen here moves on the next rising edge.
always @(negedge clk_156m)
begin
    tm_pkg::port_id_t src;
    int               tag;
    for (int j = 0; j < `NUM_PORTS; j++)
    begin
        if (arst_n && !tx_src_rdy_n[j] && !tx_dst_rdy_n[j])
        begin
            if (!busy[j])
            begin
                tag = int'(tx_beat[j].data >> (2 * PW));
                if (tag >= NUM_FRAMES)
                    report_error($sformatf("unknown packet tag %0d on output %0d", tag, j));
                else
                begin
                    src = tbl[tag].src;
                    check_port("destination", tm_pkg::port_id_t'(j), tbl[tag].dst);
                    if (exp_q[src][j].size() == 0)
                        report_error($sformatf("unexpected packet from input %0d on output %0d",
                                               src, j));
                    else
                    begin
                        cur_e[j] = exp_q[src][j].pop_front();
                        cur_k[j] = 0;
                        busy[j]  = 1'b1;
                    end
                end
            end
            check_beat($sformatf("tx_beat[%0d]", j), tx_beat[j], exp_beat(cur_e[j], cur_k[j]));
            cur_k[j]++;
            if (cur_k[j] == int'(tbl[cur_e[j]].len))
                busy[j] = 1'b0;
        end
    end
end

// Sink back-pressure.
initial
begin
    tx_dst_rdy_n = '0;
    rnd          = 32'd72;
    forever
    begin
        tick();
        rnd          = xorshift32(rnd);
        tx_dst_rdy_n = hold_mask | (rand_bp ? tm_pkg::port_vec_t'(rnd >> 7) : '0);
    end
end

// ------------------------------
// Stimulus
// ------------------------------
initial
begin
    arst_n       = 1'b0;
    channel_up   = '1;
    rx_src_rdy_n = '1;
    for (int i = 0; i < `NUM_PORTS; i++)
        rx_beat[i] = tm_pkg::ll_beat_t'{data: '0, rem: 1'b1, sof_n: 1'b1, eof_n: 1'b1};

    // Phase, source, destination, length, expected drop.
    tbl = '{
        make_frame(0, 0, 2, 5, 0),                              // Single frame.
        make_frame(1, 0, 1, 4, 0), make_frame(1, 1, 2, 6, 0),   // Four disjoint paths.
        make_frame(1, 2, 3, 3, 0), make_frame(1, 3, 0, 7, 0),
        make_frame(2, 0, 2, 3, 0), make_frame(2, 0, 2, 5, 0),   // All into output 2.
        make_frame(2, 1, 2, 1, 0), make_frame(2, 1, 2, 4, 0),
        make_frame(2, 2, 2, 6, 0), make_frame(2, 3, 2, 2, 0),
        make_frame(2, 3, 2, 8, 0),
        make_frame(3, 0, 3, 8, 0), make_frame(3, 0, 1, 2, 0),   // Random back-pressure.
        make_frame(3, 1, 0, 5, 0), make_frame(3, 1, 0, 3, 0),
        make_frame(3, 2, 1, 7, 0), make_frame(3, 3, 2, 4, 0),
        make_frame(3, 3, 3, 6, 0), make_frame(3, 2, 0, 1, 0),
        make_frame(4, 0, 1, 3, 0), make_frame(4, 0, 1, 4, 0),   // Output 1 stalled.
        make_frame(4, 0, 1, 2, 0), make_frame(4, 0, 1, 5, 0),
        make_frame(4, 0, 1, 3, 1), make_frame(4, 0, 1, 2, 1),
        make_frame(5, 3, 0, 4, 1), make_frame(5, 3, 1, 3, 1),   // Input 3 down.
        make_frame(5, 0, 1, 5, 0), make_frame(5, 1, 2, 4, 0),
        make_frame(5, 2, 0, 3, 0),
        make_frame(6, 3, 0, 4, 0), make_frame(6, 3, 2, 5, 0)    // Input 3 back up.
    };

    repeat (3) @(posedge clk_156m);
    #1;
    arst_n = 1'b1;
    tick();

    for (int ph = 0; ph < NUM_PHASES; ph++)
    begin
        hold_mask    = (ph == 4) ? tm_pkg::port_vec_t'(2) : '0;
        rand_bp      = (ph == 2 || ph == 3);
        channel_up   = (ph == 5) ? ~tm_pkg::port_vec_t'(8) : '1;
        senders_done = 0;
        for (int i = 0; i < `NUM_PORTS; i++)
        begin
            fork
                automatic int src = i;
                send_frames(src, ph);
            join_none
        end
        wait_phase_end(ph);
    end

    if (error_count == 0)
        $display("No errors");
    else
        $display("Errors found");
    $finish;
end

endmodule

// ==== design/pkt_tm.sv ====
// Switch top level; one receiver and one transmitter per port joined by the crossbar matrices.

`timescale 1ns/1ps
`include "tm_config.svh"

module pkt_tm (
    input  logic                clk_156m,
    input  logic                arst_n,
    input  tm_pkg::port_vec_t   channel_up,
    input  tm_pkg::ll_beat_t    rx_beat [`NUM_PORTS],
    input  tm_pkg::port_vec_t   rx_src_rdy_n,
    output tm_pkg::ll_beat_t    tx_beat [`NUM_PORTS],
    output tm_pkg::port_vec_t   tx_src_rdy_n,
    input  tm_pkg::port_vec_t   tx_dst_rdy_n
);

// Indexed [input][output] on the rx side and [output][input] on the tx side.
tm_pkg::port_vec_t      pkt_rdy_rx   [`NUM_PORTS];
tm_pkg::port_vec_t      pkt_rdy_tx   [`NUM_PORTS];
tm_pkg::pkt_desc_t      head_desc_rx [`NUM_PORTS][`NUM_PORTS];
tm_pkg::pkt_desc_t      head_desc_tx [`NUM_PORTS][`NUM_PORTS];
logic [`DATA_W-1:0]     rd_word_rx   [`NUM_PORTS][`NUM_PORTS];
logic [`DATA_W-1:0]     rd_word_tx   [`NUM_PORTS][`NUM_PORTS];
tm_pkg::port_vec_t      pkt_done_tx  [`NUM_PORTS];
tm_pkg::port_vec_t      pkt_done_rx  [`NUM_PORTS];
tm_pkg::xpt_addr_t      rd_addr      [`NUM_PORTS];   // Per output, seen by every input.

// ------------------------------
// Crossbar transpose
// ------------------------------
for (genvar i = 0; i < `NUM_PORTS; i++)
begin : g_row
    for (genvar j = 0; j < `NUM_PORTS; j++)
    begin : g_col
        assign pkt_rdy_tx[j][i]   = pkt_rdy_rx[i][j];
        assign head_desc_tx[j][i] = head_desc_rx[i][j];
        assign rd_word_tx[j][i]   = rd_word_rx[i][j];
        assign pkt_done_rx[i][j]  = pkt_done_tx[j][i];
    end
end

// ------------------------------
// Port instances
// ------------------------------
for (genvar p = 0; p < `NUM_PORTS; p++)
begin : g_port
    pkt_rx_tm u_pkt_rx_tm (
        .clk_156m       (clk_156m),
        .arst_n         (arst_n),
        .channel_up     (channel_up[p]),
        .rx_beat        (rx_beat[p]),
        .rx_src_rdy_n   (rx_src_rdy_n[p]),
        .pkt_rdy        (pkt_rdy_rx[p]),
        .head_desc      (head_desc_rx[p]),
        .rd_addr        (rd_addr),
        .rd_word        (rd_word_rx[p]),
        .pkt_done       (pkt_done_rx[p])
    );

    pkt_tx_tm u_pkt_tx_tm (
        .clk_156m       (clk_156m),
        .arst_n         (arst_n),
        .channel_up     (channel_up[p]),
        .pkt_rdy        (pkt_rdy_tx[p]),
        .head_desc      (head_desc_tx[p]),
        .rd_addr        (rd_addr[p]),
        .rd_word        (rd_word_tx[p]),
        .pkt_done       (pkt_done_tx[p]),
        .tx_beat        (tx_beat[p]),
        .tx_src_rdy_n   (tx_src_rdy_n[p]),
        .tx_dst_rdy_n   (tx_dst_rdy_n[p])
    );
end

endmodule

// ==== design/pkt_tx_tm.sv ====
// Per-output transmitter; round-robin over the inputs and a LocalLink sender with back-pressure.

`timescale 1ns/1ps
`include "tm_config.svh"

module pkt_tx_tm (
    input  logic                clk_156m,
    input  logic                arst_n,
    input  logic                channel_up,
    input  tm_pkg::port_vec_t   pkt_rdy,
    input  tm_pkg::pkt_desc_t   head_desc [`NUM_PORTS],
    output tm_pkg::xpt_addr_t   rd_addr,
    input  logic [`DATA_W-1:0]  rd_word [`NUM_PORTS],
    output tm_pkg::port_vec_t   pkt_done,
    output tm_pkg::ll_beat_t    tx_beat,
    output logic                tx_src_rdy_n,
    input  logic                tx_dst_rdy_n
);

logic                   port_rst_n;
tm_pkg::tx_state_t      state;
tm_pkg::port_id_t       src_q;      // Source being served, or last served.
tm_pkg::port_id_t       pick;
tm_pkg::pkt_desc_t      desc_q;
logic [`LEN_W-1:0]      left_q;     // Words not yet loaded into tx_beat.
logic                   xfer;
logic                   load;

assign port_rst_n = arst_n & channel_up;
assign xfer       = ~tx_src_rdy_n & ~tx_dst_rdy_n;
assign load       = (state == tm_pkg::TX_SEND) & (tx_src_rdy_n | xfer) & (left_q != '0);

// ------------------------------
// Round-robin source choice
// ------------------------------
always_comb
begin
    int idx;
    pick = src_q;
    // Walk backwards so the nearest ready source after src_q wins.
    for (int k = `NUM_PORTS; k >= 1; k--)
    begin
        idx = (int'(src_q) + k) % `NUM_PORTS;
        if (pkt_rdy[idx])
            pick = tm_pkg::port_id_t'(idx);
    end
end

always_comb
begin
    pkt_done = '0;
    if (state == tm_pkg::TX_DONE)
        pkt_done[src_q] = 1'b1;     // Pops the head of the served crosspoint.
end

// ------------------------------
// Control FSM
// ------------------------------
always_ff @(posedge clk_156m or negedge port_rst_n)
begin
    if (!port_rst_n)
    begin
        state        <= tm_pkg::TX_IDLE;
        src_q        <= tm_pkg::port_id_t'(`NUM_PORTS - 1);   // Input 0 goes first.
        rd_addr      <= '0;
        left_q       <= '0;
        tx_src_rdy_n <= 1'b1;
    end
    else
    begin
        case (state)
            tm_pkg::TX_IDLE:
            begin
                if (|pkt_rdy)
                begin
                    src_q   <= pick;
                    rd_addr <= head_desc[pick].start;
                    left_q  <= head_desc[pick].len;
                    state   <= tm_pkg::TX_SEND;
                end
            end
            tm_pkg::TX_SEND:
            begin
                if (load)
                begin
                    rd_addr      <= rd_addr + 1'b1;
                    left_q       <= left_q - 1'b1;
                    tx_src_rdy_n <= 1'b0;
                end
                else if (xfer)
                begin
                    tx_src_rdy_n <= 1'b1;        // Last beat has gone.
                    state        <= tm_pkg::TX_DONE;
                end
            end
            tm_pkg::TX_DONE:
                state <= tm_pkg::TX_IDLE;
            default:
                state <= tm_pkg::TX_IDLE;
        endcase
    end
end

// Output beat, held while the sink stalls.
always_ff @(posedge clk_156m)
begin
    if (state == tm_pkg::TX_IDLE)
        desc_q <= head_desc[pick];
    if (load)
    begin
        tx_beat.data  <= rd_word[src_q];
        tx_beat.sof_n <= (left_q != desc_q.len);
        tx_beat.eof_n <= (left_q != `LEN_W'(1));
        tx_beat.rem   <= (left_q == `LEN_W'(1)) ? desc_q.rem : 1'b1;
    end
end

endmodule

// ==== design/pkt_rx_tm.sv ====
// Per-input receiver; routes each frame to one crosspoint or drops it at its first word.

`timescale 1ns/1ps
`include "tm_config.svh"

module pkt_rx_tm (
    input  logic                clk_156m,
    input  logic                arst_n,
    input  logic                channel_up,
    input  tm_pkg::ll_beat_t    rx_beat,
    input  logic                rx_src_rdy_n,
    output tm_pkg::port_vec_t   pkt_rdy,
    output tm_pkg::pkt_desc_t   head_desc [`NUM_PORTS],
    input  tm_pkg::xpt_addr_t   rd_addr [`NUM_PORTS],
    output logic [`DATA_W-1:0]  rd_word [`NUM_PORTS],
    input  tm_pkg::port_vec_t   pkt_done
);

logic                   port_rst_n;
logic                   beat_vld;
logic                   is_sof;
logic                   is_eof;
tm_pkg::port_id_t       sof_dest;
tm_pkg::port_id_t       tgt_q;
tm_pkg::port_id_t       tgt_now;
logic                   keep_q;
logic                   keep_now;
tm_pkg::port_vec_t      can_accept;
tm_pkg::port_vec_t      wr_en;

assign port_rst_n = arst_n & channel_up;     // Channel down holds the port in reset.
assign beat_vld   = ~rx_src_rdy_n;
assign is_sof     = beat_vld & ~rx_beat.sof_n;
assign is_eof     = beat_vld & ~rx_beat.eof_n;
assign sof_dest   = rx_beat.data[$bits(tm_pkg::port_id_t)-1:0];

// Decision on the sof beat itself, latched for the rest of the frame.
assign keep_now = is_sof ? can_accept[sof_dest] : keep_q;
assign tgt_now  = is_sof ? sof_dest : tgt_q;

always_ff @(posedge clk_156m or negedge port_rst_n)
begin
    if (!port_rst_n)
    begin
        keep_q <= 1'b0;
        tgt_q  <= '0;
    end
    else if (beat_vld)
    begin
        keep_q <= keep_now & ~is_eof;
        tgt_q  <= tgt_now;
    end
end

// ------------------------------
// Crosspoints, one per output
// ------------------------------
for (genvar j = 0; j < `NUM_PORTS; j++)
begin : g_xpt
    assign wr_en[j] = beat_vld & keep_now & (tgt_now == tm_pkg::port_id_t'(j));

    pkt_xpt_buf u_xpt_buf (
        .clk_156m   (clk_156m),
        .arst_n     (port_rst_n),
        .wr_en      (wr_en[j]),
        .wr_data    (rx_beat.data),
        .wr_last    (is_eof),
        .wr_rem     (rx_beat.rem),
        .can_accept (can_accept[j]),
        .pkt_rdy    (pkt_rdy[j]),
        .head_desc  (head_desc[j]),
        .rd_addr    (rd_addr[j]),
        .rd_data    (rd_word[j]),
        .pkt_done   (pkt_done[j])
    );
end

endmodule

// ==== design/pkt_xpt_buf.sv ====
// One crosspoint buffer, written by its input's receiver and drained by one output's transmitter.

`timescale 1ns/1ps
`include "tm_config.svh"

module pkt_xpt_buf (
    input  logic                clk_156m,
    input  logic                arst_n,
    input  logic                wr_en,
    input  logic [`DATA_W-1:0]  wr_data,
    input  logic                wr_last,
    input  logic                wr_rem,
    output logic                can_accept,
    output logic                pkt_rdy,
    output tm_pkg::pkt_desc_t   head_desc,
    input  tm_pkg::xpt_addr_t   rd_addr,
    output logic [`DATA_W-1:0]  rd_data,
    input  logic                pkt_done
);

localparam int BUF_WORDS = 2 ** `XPT_AW;
localparam int CNT_W     = `XPT_AW + 1;
localparam int QAW       = $clog2(`DESC_DEPTH);

logic [`DATA_W-1:0]     mem [BUF_WORDS];
tm_pkg::pkt_desc_t      desc_mem [`DESC_DEPTH];
tm_pkg::xpt_addr_t      wr_ptr;
tm_pkg::xpt_addr_t      frm_start;      // First word of the frame being written.
logic [`LEN_W-1:0]      frm_len;
logic [CNT_W-1:0]       used;
logic [QAW-1:0]         q_wr;
logic [QAW-1:0]         q_rd;
logic [QAW:0]           q_cnt;
logic                   push;
tm_pkg::pkt_desc_t      new_desc;

assign push           = wr_en & wr_last;
assign new_desc.start = frm_start;
assign new_desc.len   = frm_len + 1'b1;
assign new_desc.rem   = wr_rem;

assign head_desc  = desc_mem[q_rd];
assign pkt_rdy    = (q_cnt != '0);
assign rd_data    = mem[rd_addr];   // Combinational read for the tx side.
assign can_accept = (q_cnt != (QAW+1)'(`DESC_DEPTH)) &&
                    (used <= CNT_W'(BUF_WORDS - `PKT_MAX_WORDS));

// ------------------------------
// Storage
// ------------------------------
always_ff @(posedge clk_156m)
begin
    if (wr_en)
        mem[wr_ptr] <= wr_data;
    if (push)
        desc_mem[q_wr] <= new_desc;
end

// ------------------------------
// Pointers and accounting
// ------------------------------
always_ff @(posedge clk_156m or negedge arst_n)
begin
    if (!arst_n)
    begin
        wr_ptr    <= '0;
        frm_start <= '0;
        frm_len   <= '0;
        used      <= '0;
        q_wr      <= '0;
        q_rd      <= '0;
        q_cnt     <= '0;
    end
    else
    begin
        if (wr_en)
        begin
            wr_ptr  <= wr_ptr + 1'b1;
            frm_len <= wr_last ? '0 : frm_len + 1'b1;
            if (wr_last)
                frm_start <= wr_ptr + 1'b1;     // Next frame starts after this one.
        end
        // Words come back only when the whole packet has left.
        used <= used + CNT_W'(wr_en) - (pkt_done ? CNT_W'(head_desc.len) : '0);
        if (push)
            q_wr <= (q_wr == QAW'(`DESC_DEPTH - 1)) ? '0 : q_wr + 1'b1;
        if (pkt_done)
            q_rd <= (q_rd == QAW'(`DESC_DEPTH - 1)) ? '0 : q_rd + 1'b1;
        q_cnt <= q_cnt + (QAW+1)'(push) - (QAW+1)'(pkt_done);
    end
end

endmodule

// ==== design/tm_pkg.sv ====
// Shared types of the packet switch, referenced by scoped name from the RTL modules.

`include "tm_config.svh"

package tm_pkg;

    // ------------------------------
    // Index and vector types
    // ------------------------------
    typedef logic [$clog2(`NUM_PORTS)-1:0] port_id_t;  // From the low bits of the first word.
    typedef logic [`NUM_PORTS-1:0]         port_vec_t; // One bit per port.
    typedef logic [`XPT_AW-1:0]            xpt_addr_t;

    // One LocalLink beat.
    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic               rem;    // 1 means both bytes valid.
        logic               sof_n;
        logic               eof_n;
    } ll_beat_t;

    // Stored packet in a crosspoint buffer.
    typedef struct packed {
        xpt_addr_t          start;
        logic [`LEN_W-1:0]  len;    // Words.
        logic               rem;    // rem of the last word.
    } pkt_desc_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_DONE
    } tx_state_t;

endpackage

// ==== design/tm_config.svh ====
// Sizing macros for the packet switch, included by the package and every RTL module.

`ifndef TM_CONFIG_SVH
`define TM_CONFIG_SVH

// ------------------------------
// Port count and LocalLink width
// ------------------------------
`define NUM_PORTS       4
`define DATA_W          16

// ------------------------------
// Crosspoint buffering
// ------------------------------
`define XPT_AW          6       // 64 words per crosspoint.
`define DESC_DEPTH      4       // Packets queued per crosspoint.
`define PKT_MAX_WORDS   16      // Longest frame accepted.
`define LEN_W           5       // Holds a length of PKT_MAX_WORDS.

`endif
